//--- src.f
logic/lsu_op_pkg.sv
logic/lsu_word_pkg.sv
logic/lsu_access_if.sv
logic/lsu_ctrl.sv
logic/store_align.sv
logic/data_ram.sv
logic/load_extract.sv
logic/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - logic/lsu_op_pkg.sv
  - logic/lsu_word_pkg.sv
  - logic/lsu_access_if.sv
  - logic/lsu_ctrl.sv
  - logic/store_align.sv
  - logic/data_ram.sv
  - logic/load_extract.sv
  - logic/lsu_top.sv
  - target: test
    files:
      - dv/lsu_checker.sv
      - dv/lsu_tb.sv

//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  logic clk;
  logic rst;
  logic req_valid;
  logic req_write;
  logic [2:0] req_op;
  logic [9:0] req_addr;
  logic [63:0] req_wdata;
  logic rsp_valid;
  logic [63:0] rsp_rdata;
  logic err;

  // reference byte memory in ram lane order
  logic [7:0] ref_mem [0:1023];
  // expected load data and the cycle it is due in
  logic [63:0] exp_data_q[$];
  int exp_due_q[$];
  // cycles in which err must be high
  int err_due_q[$];
  int cyc;
  logic [31:0] rng;

  lsu_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_rdata (rsp_rdata),
    .err       (err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic stop_on_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
      stop_on_failure();
    end
  endtask

  // apply one request to the model
  // t is the cycle its strobe is high in
  task automatic model_request(input logic w, input logic [2:0] op, input logic [9:0] addr,
                               input logic [63:0] wdata, input int t);
    int nbytes;
    logic legal;
    logic [63:0] val;
    nbytes = 1 << op[1:0];
    legal = w ? (op < 3'd4) : (op != 3'd7);
    if (!legal || (int'(addr) % nbytes) != 0) begin
      // rejected requests leave memory alone
      err_due_q.push_back(t + 1);
    end else if (w) begin
      for (int k = 0; k < nbytes; k++) begin
        ref_mem[int'(addr) + k] = wdata[8*k +: 8];
      end
    end else begin
      val = '0;
      for (int k = 0; k < nbytes; k++) begin
        val[8*k +: 8] = ref_mem[int'(addr) + k];
      end
      // codes 0 to 2 extend the sign
      // codes 4 to 6 fill with zeros
      if (!op[2] && val[8*nbytes-1]) begin
        for (int k = nbytes; k < 8; k++) begin
          val[8*k +: 8] = 8'hff;
        end
      end
      exp_data_q.push_back(val);
      exp_due_q.push_back(t + 2);
    end
  endtask

  // outputs sampled mid cycle away from the clock edge
  task automatic check_outputs();
    logic exp_rsp;
    logic exp_err;
    exp_rsp = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
    exp_err = (err_due_q.size() > 0) && (err_due_q[0] == cyc);
    compare("rsp_valid", 64'(rsp_valid), 64'(exp_rsp));
    compare("err", 64'(err), 64'(exp_err));
    if (exp_rsp) begin
      compare("rsp_rdata", rsp_rdata, exp_data_q[0]);
      void'(exp_data_q.pop_front());
      void'(exp_due_q.pop_front());
    end
    if (exp_err) begin
      void'(err_due_q.pop_front());
    end
  endtask

  // one clock cycle with a request or idle
  task automatic issue(input logic v, input logic w, input logic [2:0] op,
                       input logic [9:0] addr, input logic [63:0] wdata);
    @(posedge clk);
    req_valid <= v;
    req_write <= w;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    if (v) begin
      model_request(w, op, addr, wdata, cyc + 1);
    end
    @(negedge clk);
    cyc++;
    check_outputs();
  endtask

  task automatic run_idle(input int n);
    for (int i = 0; i < n; i++) begin
      issue(1'b0, 1'b0, 3'd0, 10'd0, 64'd0);
    end
  endtask

  // let outstanding responses come back
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_due_q.size() > 0 || err_due_q.size() > 0) begin
      if (waited == 20) begin
        $display("responses still outstanding after %0d idle cycles", waited);
        stop_on_failure();
      end
      run_idle(1);
      waited++;
    end
  endtask

  task automatic wait_reset_quiet();
    int waited;
    waited = 0;
    while (rsp_valid !== 1'b0 || err !== 1'b0) begin
      if (waited == 20) begin
        $display("outputs did not settle low after reset");
        stop_on_failure();
      end
      @(negedge clk);
      waited++;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [2:0] op;
    logic [9:0] addr;
    logic w;
    cyc = 0;
    rng = 32'ha13e0966;
    rst = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_op = 3'd0;
    req_addr = '0;
    req_wdata = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    wait_reset_quiet();
    // quiet outputs after reset with no requests
    run_idle(5);
    // fill the low 64 bytes with known doubles
    for (int a = 0; a < 64; a += 8) begin
      issue(1'b1, 1'b1, 3'd3, 10'(a), {rand32(), rand32()});
    end
    // each store size then a double readback
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        issue(1'b1, 1'b1, 3'(s), 10'(16 + off), {rand32(), rand32()});
        issue(1'b1, 1'b0, 3'd3, 10'd16, 64'd0);
      end
    end
    // signed and unsigned loads at all aligned offsets
    for (int round = 0; round < 4; round++) begin
      issue(1'b1, 1'b1, 3'd3, 10'd24, {rand32(), rand32()});
      for (int c = 0; c < 7; c++) begin
        if (c != 3) begin
          for (int off = 0; off < 8; off += (1 << c[1:0])) begin
            issue(1'b1, 1'b0, 3'(c), 10'(24 + off), 64'd0);
          end
        end
      end
    end
    // illegal codes and misaligned addresses
    for (int c = 4; c < 8; c++) begin
      issue(1'b1, 1'b1, 3'(c), 10'd32, {rand32(), rand32()});
    end
    issue(1'b1, 1'b0, 3'd7, 10'd32, 64'd0);
    issue(1'b1, 1'b0, 3'd1, 10'd33, 64'd0);
    issue(1'b1, 1'b0, 3'd6, 10'd34, 64'd0);
    issue(1'b1, 1'b0, 3'd3, 10'd36, 64'd0);
    issue(1'b1, 1'b1, 3'd1, 10'd35, {rand32(), rand32()});
    issue(1'b1, 1'b1, 3'd3, 10'd44, {rand32(), rand32()});
    // memory must be unchanged
    for (int a = 0; a < 64; a += 8) begin
      issue(1'b1, 1'b0, 3'd3, 10'(a), 64'd0);
    end
    // load right behind a store to the same word
    issue(1'b1, 1'b1, 3'd3, 10'd40, {rand32(), rand32()});
    issue(1'b1, 1'b0, 3'd3, 10'd40, 64'd0);
    issue(1'b1, 1'b1, 3'd0, 10'd43, {rand32(), rand32()});
    issue(1'b1, 1'b0, 3'd4, 10'd43, 64'd0);
    issue(1'b1, 1'b1, 3'd1, 10'd46, {rand32(), rand32()});
    issue(1'b1, 1'b0, 3'd1, 10'd46, 64'd0);
    // back to back random traffic in the low 64 bytes
    for (int n = 0; n < 4000; n++) begin
      r = rand32();
      w = r[3];
      op = r[6:4];
      // keep most stores on legal codes
      if (w && r[7]) begin
        op[2] = 1'b0;
      end
      addr = 10'(r[13:8]);
      if (r[15:14] != 2'b00) begin
        addr = addr & ~10'((1 << op[1:0]) - 1);
      end
      issue(r[0] | r[1] | r[2], w, op, addr, {rand32(), rand32()});
    end
    drain();
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- dv/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
  input logic clk,
  input logic rst,
  input logic req_valid,
  input logic req_write,
  input logic rsp_valid,
  input logic err
);

  // load response two cycles behind its request
  rsp_follows_load: assert property (
    @(posedge clk) disable iff (rst)
    rsp_valid |-> $past(req_valid && !req_write, 2)
  ) else $error("rsp_valid with no load request two cycles earlier");

  // err one cycle behind the rejected request
  err_follows_req: assert property (
    @(posedge clk) disable iff (rst)
    err |-> $past(req_valid)
  ) else $error("err with no request one cycle earlier");

  // strobes cleared by reset
  quiet_in_reset: assert property (
    @(posedge clk)
    rst |=> (!rsp_valid && !err)
  ) else $error("rsp_valid or err high while in reset");

endmodule

bind lsu_top lsu_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .req_valid (req_valid),
  .req_write (req_write),
  .rsp_valid (rsp_valid),
  .err       (err)
);

//--- logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int addr_w = 10
) (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic req_write,
  input  lsu_op_pkg::mem_op_t req_op,
  input  logic [addr_w-1:0] req_addr,
  input  logic [lsu_word_pkg::data_w-1:0] req_wdata,
  output logic rsp_valid,
  output logic [lsu_word_pkg::data_w-1:0] rsp_rdata,
  output logic err
);

  // raw ram word, valid with rsp_valid
  logic [lsu_word_pkg::data_w-1:0] ram_rdata;

  // decoded access between control and datapath
  lsu_access_if #(.addr_w(addr_w)) acc ();

  // decode, checks and strobes
  lsu_ctrl #(.addr_w(addr_w)) u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_write (req_write),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .acc       (acc.ctrl),
    .rsp_valid (rsp_valid),
    .err       (err)
  );

  // store lanes and byte mask
  store_align u_store (
    .acc (acc.store)
  );

  data_ram #(.addr_w(addr_w)) u_ram (
    .clk   (clk),
    .acc   (acc.ram),
    .rdata (ram_rdata)
  );

  // load lane select and extension
  load_extract u_load (
    .rdata     (ram_rdata),
    .acc       (acc.load),
    .rsp_rdata (rsp_rdata)
  );

endmodule

//--- logic/load_extract.sv
`timescale 1ns/1ps

module load_extract (
  input  logic [lsu_word_pkg::data_w-1:0] rdata,
  lsu_access_if.load acc,
  output logic [lsu_word_pkg::data_w-1:0] rsp_rdata
);

  localparam int data_w = lsu_word_pkg::data_w;
  localparam int off_w  = lsu_word_pkg::off_w;

  lsu_word_pkg::word_view_u word;
  logic [7:0] sel_b;
  logic [15:0] sel_h;
  logic [31:0] sel_w;
  // sign bit of the picked element
  logic fill;

  // pick lanes by offset
  always_comb begin
    word.d = rdata;
    sel_b  = word.b[acc.s2_off];
    // low offset bits are zero for halves and words
    sel_h  = word.h[acc.s2_off[off_w-1:1]];
    sel_w  = word.w[acc.s2_off[off_w-1]];
  end

  // sign or zero extension
  always_comb begin
    case (acc.s2_size)
      lsu_op_pkg::size_b: begin
        fill      = acc.s2_signed & sel_b[7];
        rsp_rdata = {{(data_w-8){fill}}, sel_b};
      end
      lsu_op_pkg::size_h: begin
        fill      = acc.s2_signed & sel_h[15];
        rsp_rdata = {{(data_w-16){fill}}, sel_h};
      end
      lsu_op_pkg::size_w: begin
        fill      = acc.s2_signed & sel_w[31];
        rsp_rdata = {{(data_w-32){fill}}, sel_w};
      end
      default: begin
        // double goes straight through
        fill      = 1'b0;
        rsp_rdata = word.d;
      end
    endcase
  end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int addr_w = 10
) (
  input  logic clk,
  lsu_access_if.ram acc,
  output logic [lsu_word_pkg::data_w-1:0] rdata
);

  localparam int lanes = lsu_word_pkg::lanes;
  localparam int depth = 2 ** (addr_w - lsu_word_pkg::off_w);

  // word storage, split into byte lanes
  logic [lanes-1:0][7:0] mem [depth];

  // byte write enables
  always_ff @(posedge clk) begin
    if (acc.s1_we) begin
      for (int i = 0; i < lanes; i++) begin
        if (acc.lane_mask[i]) begin
          mem[acc.s1_index][i] <= acc.lane_data[i*8 +: 8];
        end
      end
    end
  end

  // registered read, one cycle after s1_re
  // we and re never both high, one request per cycle
  always_ff @(posedge clk) begin
    if (acc.s1_re) begin
      rdata <= mem[acc.s1_index];
    end
  end

endmodule

//--- logic/store_align.sv
`timescale 1ns/1ps

module store_align (
  lsu_access_if.store acc
);

  localparam int lanes = lsu_word_pkg::lanes;

  lsu_word_pkg::word_view_u src;
  lsu_word_pkg::word_view_u rep;
  logic [lanes-1:0] base_mask;

  // copy the low element into every lane of its size
  always_comb begin
    src.d = acc.s1_wdata;
    rep.d = src.d;
    case (acc.s1_size)
      lsu_op_pkg::size_b: begin
        for (int i = 0; i < lanes; i++) begin
          rep.b[i] = src.b[0];
        end
      end
      lsu_op_pkg::size_h: begin
        for (int i = 0; i < lsu_word_pkg::halves; i++) begin
          rep.h[i] = src.h[0];
        end
      end
      lsu_op_pkg::size_w: begin
        for (int i = 0; i < lsu_word_pkg::words; i++) begin
          rep.w[i] = src.w[0];
        end
      end
      default: begin
        // double, already in place
        rep.d = src.d;
      end
    endcase
  end

  // lanes covered at offset zero
  always_comb begin
    case (acc.s1_size)
      lsu_op_pkg::size_b: base_mask = lanes'(8'h01);
      lsu_op_pkg::size_h: base_mask = lanes'(8'h03);
      lsu_op_pkg::size_w: base_mask = lanes'(8'h0f);
      default:            base_mask = '1;
    endcase
  end

  assign acc.lane_data = rep.d;
  // offset is aligned, so the shift never drops a bit
  assign acc.lane_mask = base_mask << acc.s1_off;

endmodule

//--- logic/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl #(
  parameter int addr_w = 10
) (
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  input  logic req_write,
  input  lsu_op_pkg::mem_op_t req_op,
  input  logic [addr_w-1:0] req_addr,
  input  logic [lsu_word_pkg::data_w-1:0] req_wdata,
  lsu_access_if.ctrl acc,
  output logic rsp_valid,
  output logic err
);

  localparam int off_w = lsu_word_pkg::off_w;

  lsu_op_pkg::acc_size_t req_size;
  logic [off_w-1:0] req_off;
  logic req_legal;
  logic req_aligned;
  logic req_ok;
  // sign flag waits here one stage
  logic s1_signed;

  // decode and check
  always_comb begin
    req_size  = lsu_op_pkg::op_size(req_op);
    req_legal = lsu_op_pkg::op_legal(req_op, req_write);
    req_off   = req_addr[off_w-1:0];
    // natural alignment, low offset bits must be zero
    case (req_size)
      lsu_op_pkg::size_b: req_aligned = 1'b1;
      lsu_op_pkg::size_h: req_aligned = (req_off[0] == 1'b0);
      lsu_op_pkg::size_w: req_aligned = (req_off[1:0] == 2'b00);
      default:            req_aligned = (req_off == '0);
    endcase
    req_ok = req_legal && req_aligned;
  end

  // strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      acc.s1_we <= 1'b0;
      acc.s1_re <= 1'b0;
      err       <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      acc.s1_we <= req_valid && req_write && req_ok;
      acc.s1_re <= req_valid && !req_write && req_ok;
      // rejected requests never reach the ram
      err       <= req_valid && !req_ok;
      // ram read data lands together with this
      rsp_valid <= acc.s1_re;
    end
  end

  // stage one payload
  always_ff @(posedge clk) begin
    if (req_valid) begin
      acc.s1_index <= req_addr[addr_w-1:off_w];
      acc.s1_off   <= req_off;
      acc.s1_size  <= req_size;
      acc.s1_wdata <= req_wdata;
      s1_signed    <= lsu_op_pkg::op_signed(req_op);
    end
  end

  // stage two payload, held until the next load
  always_ff @(posedge clk) begin
    if (acc.s1_re) begin
      acc.s2_off    <= acc.s1_off;
      acc.s2_size   <= acc.s1_size;
      acc.s2_signed <= s1_signed;
    end
  end

endmodule

//--- logic/lsu_access_if.sv
`timescale 1ns/1ps

interface lsu_access_if #(
  parameter int addr_w = 10
);

  // stage one, valid the cycle after the request
  logic s1_we;
  logic s1_re;
  logic [addr_w-lsu_word_pkg::off_w-1:0] s1_index;
  logic [lsu_word_pkg::off_w-1:0] s1_off;
  lsu_op_pkg::acc_size_t s1_size;
  logic [lsu_word_pkg::data_w-1:0] s1_wdata;

  // stage two, loads only
  logic [lsu_word_pkg::off_w-1:0] s2_off;
  lsu_op_pkg::acc_size_t s2_size;
  logic s2_signed;

  // byte lanes from store_align
  logic [lsu_word_pkg::data_w-1:0] lane_data;
  logic [lsu_word_pkg::lanes-1:0] lane_mask;

  modport ctrl (
    output s1_we, s1_re, s1_index, s1_off, s1_size, s1_wdata,
    output s2_off, s2_size, s2_signed
  );

  modport store (input s1_off, s1_size, s1_wdata, output lane_data, lane_mask);

  modport ram (input s1_we, s1_re, s1_index, lane_data, lane_mask);

  modport load (input s2_off, s2_size, s2_signed);

endinterface

//--- logic/lsu_word_pkg.sv
package lsu_word_pkg;

  // data word geometry
  localparam int data_w = 64;
  localparam int lanes  = data_w / 8;
  // byte offset within one word
  localparam int off_w  = $clog2(lanes);

  localparam int halves = lanes / 2;
  localparam int words  = lanes / 4;

  // one data word, several lane views
  // lane 0 always sits at the low end
  typedef union packed {
    // whole double
    logic [data_w-1:0] d;
    // byte lanes
    logic [lanes-1:0][7:0] b;
    // half lanes
    logic [halves-1:0][15:0] h;
    // word lanes
    logic [words-1:0][31:0] w;
  } word_view_u;

endpackage

//--- logic/lsu_op_pkg.sv
package lsu_op_pkg;

  // width code, same layout as risc-v funct3
  typedef logic [2:0] mem_op_t;

  localparam mem_op_t op_lb  = 3'd0;
  localparam mem_op_t op_lh  = 3'd1;
  localparam mem_op_t op_lw  = 3'd2;
  localparam mem_op_t op_ld  = 3'd3;
  localparam mem_op_t op_lbu = 3'd4;
  localparam mem_op_t op_lhu = 3'd5;
  localparam mem_op_t op_lwu = 3'd6;
  localparam mem_op_t op_bad = 3'd7;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } acc_size_t;

  // stores only take the signed codes, loads anything but 7
  function automatic logic op_legal(input mem_op_t op, input logic write);
    if (write) begin
      return op inside {op_lb, op_lh, op_lw, op_ld};
    end
    return op != op_bad;
  endfunction

  function automatic acc_size_t op_size(input mem_op_t op);
    case (op)
      op_lb, op_lbu: return size_b;
      op_lh, op_lhu: return size_h;
      op_lw, op_lwu: return size_w;
      default:       return size_d;
    endcase
  endfunction

  // double counts as signed, nothing left to extend anyway
  function automatic logic op_signed(input mem_op_t op);
    return !(op inside {op_lbu, op_lhu, op_lwu});
  endfunction

endpackage
